// File: compile.f
+incdir+.
rv5_pkg.sv
rv5_fwd_if.sv
rv5_fetch.sv
rv5_decoder.sv
rv5_hazard_unit.sv
rv5_regfile.sv
rv5_execute.sv
rv5_core.sv
rv5_asserts.sv
rv5_checker.sv
tb_rv5_core.sv

// File: tb_rv5_core.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module tb_rv5_core;
    localparam int PROG_LEN    = 48;
    localparam int MEM_WORDS   = 64;
    localparam int HALT_HITS   = 8;
    // four cycles for every instruction including the halt plus 40
    localparam int CYCLE_LIMIT = 4 * (PROG_LEN + 1) + 40;
    localparam logic [`RV_XLEN-1:0] HALT_PC = PROG_LEN * 4;

    logic                      clk;
    logic                      rst_n;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       instruction;
    logic [`RV_XLEN-1:0]       mem_addr;
    logic [`RV_XLEN-1:0]       mem_wdata;
    logic                      mem_re;
    logic                      mem_we;
    logic [`RV_XLEN-1:0]       mem_rdata;
    logic [`RV_REG_ADDR_W-1:0] dbg_reg_addr;
    logic [`RV_XLEN-1:0]       dbg_reg_data;
    logic                      drain;
    logic                      sweep;
    int                        checker_errors;
    int                        run_cycles;
    int                        halt_hits;
    logic [`RV_XLEN-1:0]       prog      [MEM_WORDS];
    logic [`RV_XLEN-1:0]       init_data [MEM_WORDS];
    logic [`RV_XLEN-1:0]       dmem      [MEM_WORDS];

    rv5_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .instruction  (instruction),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .mem_rdata    (mem_rdata),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    rv5_checker #(.MEM_WORDS(MEM_WORDS)) chk0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data),
        .drain        (drain),
        .sweep        (sweep),
        .prog         (prog),
        .init_data    (init_data),
        .errors       (checker_errors)
    );

    bind rv5_core rv5_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    always begin
        #20 clk = ~clk;
    end

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [6:0] opc, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // registers x0 to x7 only so that dependencies are frequent
    function automatic logic [31:0] random_instr(input int index);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        int          offset;
        rd     = 5'($urandom % 8);
        rs1    = 5'($urandom % 8);
        rs2    = 5'($urandom % 8);
        imm    = 12'($urandom);
        kind   = int'($urandom % 11);
        // forward by 2 to 5 instructions and never past the halt
        offset = 2 + int'($urandom % 4);
        if (offset > PROG_LEN - index) begin
            offset = PROG_LEN - index;
        end
        case (kind)
            0:       return r_type_word(7'h00, 3'b000, rd, rs1, rs2);
            1:       return r_type_word(7'h20, 3'b000, rd, rs1, rs2);
            2:       return r_type_word(7'h00, 3'b111, rd, rs1, rs2);
            3:       return r_type_word(7'h00, 3'b110, rd, rs1, rs2);
            4:       return r_type_word(7'h00, 3'b100, rd, rs1, rs2);
            5:       return r_type_word(7'h00, 3'b010, rd, rs1, rs2);
            6:       return i_type_word(7'b0010011, 3'b000, rd, rs1, imm);
            7:       return i_type_word(7'b0000011, 3'b010, rd, rs1, imm);
            8:       return store_word(rs1, rs2, imm);
            9:       return branch_word(3'b000, rs1, rs2, 13'(offset * 4));
            default: return branch_word(3'b001, rs1, rs2, 13'(offset * 4));
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < PROG_LEN) begin
                prog[i] = random_instr(i);
            end else if (i == PROG_LEN) begin
                // beq x0, x0, 0
                prog[i] = branch_word(3'b000, 5'd0, 5'd0, 13'd0);
            end else begin
                prog[i] = `RV_NOP;
            end
            init_data[i] = $urandom;
            dmem[i]      = init_data[i];
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < MEM_WORDS * 4) begin
            return prog[addr[7:2]];
        end
        return `RV_NOP;
    endfunction

    task automatic sweep_registers();
        for (int r = 0; r < `RV_NUM_REGS; r++) begin
            dbg_reg_addr = `RV_REG_ADDR_W'(r);
            sweep        = 1'b1;
            @(negedge clk);
        end
        sweep = 1'b0;
    endtask

    // both memories answer at the falling edge with stores landing first
    always @(negedge clk) begin
        if (rst_n && mem_we) begin
            dmem[mem_addr[7:2]] = mem_wdata;
        end
        instruction = fetch_word(pc);
        mem_rdata   = dmem[mem_addr[7:2]];
    end

    // halt detection and cycle limit
    always @(posedge clk) begin
        if (rst_n && !drain) begin
            run_cycles++;
            if (pc == HALT_PC) begin
                halt_hits++;
            end
            if (run_cycles > CYCLE_LIMIT) begin
                $display("timeout: the core did not reach the halt loop within %0d cycles",
                         CYCLE_LIMIT);
                $display("Test failures found");
                $finish;
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instruction  = `RV_NOP;
        mem_rdata    = '0;
        dbg_reg_addr = '0;
        drain        = 1'b0;
        sweep        = 1'b0;
        run_cycles   = 0;
        halt_hits    = 0;
        void'($urandom(32'he5d3_dfbe));
        build_program();
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        while (halt_hits < HALT_HITS) begin
            @(negedge clk);
        end
        drain = 1'b1;
        sweep_registers();
        $display("errors: %0d from the checker, %0d from assertions",
                 checker_errors, dut0.u_asserts.fail_count);
        if (checker_errors == 0 && dut0.u_asserts.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: rv5_checker.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_checker #(
    parameter int MEM_WORDS = 64
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`RV_XLEN-1:0]       mem_addr,
    input  logic [`RV_XLEN-1:0]       mem_wdata,
    input  logic                      mem_re,
    input  logic                      mem_we,
    input  logic [`RV_REG_ADDR_W-1:0] dbg_reg_addr,
    input  logic [`RV_XLEN-1:0]       dbg_reg_data,
    input  logic                      drain,
    input  logic                      sweep,
    input  logic [`RV_XLEN-1:0]       prog      [MEM_WORDS],
    input  logic [`RV_XLEN-1:0]       init_data [MEM_WORDS],
    output int                        errors
);
    localparam int STEP_ALU   = 0;
    localparam int STEP_LOAD  = 1;
    localparam int STEP_STORE = 2;
    localparam int STEP_HALT  = 3;
    // programs only branch forward, so this bounds any walk to the halt
    localparam int MAX_STEPS  = 4 * MEM_WORDS;

    logic [`RV_XLEN-1:0] m_regs [`RV_NUM_REGS];
    logic [`RV_XLEN-1:0] m_mem  [MEM_WORDS];
    logic [`RV_XLEN-1:0] m_pc;
    logic                drained;

    initial begin
        errors = 0;
    end

    function automatic string access_name(input int kind);
        return (kind == STEP_STORE) ? "store" : "load";
    endfunction

    // one architectural instruction at m_pc
    task automatic model_step(output int kind, output logic [`RV_XLEN-1:0] addr,
                              output logic [`RV_XLEN-1:0] data);
        logic [`RV_XLEN-1:0] w;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] res;
        logic [`RV_XLEN-1:0] next_pc;
        logic                we;
        w       = prog[m_pc[7:2]];
        a       = m_regs[w[19:15]];
        b       = m_regs[w[24:20]];
        kind    = STEP_ALU;
        addr    = '0;
        data    = '0;
        res     = '0;
        we      = 1'b0;
        next_pc = m_pc + 4;
        case (w[6:0])
            7'b0110011: begin
                we = 1'b1;
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'b000}: res = a + b;
                    {7'h20, 3'b000}: res = a - b;
                    {7'h00, 3'b111}: res = a & b;
                    {7'h00, 3'b110}: res = a | b;
                    {7'h00, 3'b100}: res = a ^ b;
                    {7'h00, 3'b010}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         we = 1'b0;
                endcase
            end
            7'b0010011: begin
                we  = 1'b1;
                res = a + {{20{w[31]}}, w[31:20]};
            end
            7'b0000011: begin
                we   = 1'b1;
                kind = STEP_LOAD;
                addr = a + {{20{w[31]}}, w[31:20]};
                res  = m_mem[addr[7:2]];
            end
            7'b0100011: begin
                kind = STEP_STORE;
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                data = b;
                m_mem[addr[7:2]] = b;
            end
            7'b1100011: begin
                if ((w[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                    next_pc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        if (we && w[11:7] != '0) begin
            m_regs[w[11:7]] = res;
        end
        // a taken branch onto itself is the halt
        if (next_pc == m_pc) begin
            kind = STEP_HALT;
        end
        m_pc = next_pc;
    endtask

    // match a DUT strobe against the next memory access in program order
    task automatic check_access(input int seen);
        int                  kind;
        int                  steps;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] data;
        kind  = STEP_ALU;
        steps = 0;
        while (kind == STEP_ALU && steps < MAX_STEPS) begin
            model_step(kind, addr, data);
            steps++;
        end
        if (kind == STEP_HALT || kind == STEP_ALU) begin
            errors++;
            $display("extra %s at address %h, the program has no memory access left",
                     access_name(seen), mem_addr);
        end else if (kind != seen) begin
            errors++;
            $display("the DUT issued a %s where the program does a %s",
                     access_name(seen), access_name(kind));
        end else if (mem_addr !== addr) begin
            errors++;
            $display("FAIL %0t: %s address %h, expected %h",
                     $time, access_name(seen), mem_addr, addr);
        end else if (seen == STEP_STORE && mem_wdata !== data) begin
            errors++;
            $display("FAIL %0t: store data %h at %h, expected %h",
                     $time, mem_wdata, mem_addr, data);
        end
    endtask

    // run the model to the halt, anything left over was never issued
    task automatic finish_model();
        int                  kind;
        int                  steps;
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] data;
        kind  = STEP_ALU;
        steps = 0;
        while (kind != STEP_HALT && steps < MAX_STEPS) begin
            model_step(kind, addr, data);
            if (kind == STEP_LOAD || kind == STEP_STORE) begin
                errors++;
                $display("missing %s at address %h, the DUT never issued it",
                         access_name(kind), addr);
            end
            steps++;
        end
        drained = 1'b1;
    endtask

    task automatic check_register();
        if (dbg_reg_data !== m_regs[dbg_reg_addr]) begin
            errors++;
            $display("FAIL %0t: x%0d reads %h, expected %h",
                     $time, dbg_reg_addr, dbg_reg_data, m_regs[dbg_reg_addr]);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                m_regs[i] = '0;
            end
            for (int i = 0; i < MEM_WORDS; i++) begin
                m_mem[i] = init_data[i];
            end
            m_pc    = `RV_RESET_PC;
            drained = 1'b0;
        end else begin
            if (mem_we) begin
                check_access(STEP_STORE);
            end else if (mem_re) begin
                check_access(STEP_LOAD);
            end
            if (drain && !drained) begin
                finish_model();
            end
            if (sweep) begin
                check_register();
            end
        end
    end

endmodule

// File: rv5_asserts.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_asserts (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`RV_XLEN-1:0]       pc,
    input  logic                      mem_re,
    input  logic                      mem_we,
    input  logic [`RV_REG_ADDR_W-1:0] dbg_reg_addr,
    input  logic [`RV_XLEN-1:0]       dbg_reg_data
);
    // failures seen so far, read back at the end of the run
    int fail_count = 0;

    strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_re && mem_we))
    else begin
        fail_count++;
        $error("mem_re and mem_we are high in the same cycle");
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
    else begin
        fail_count++;
        $error("pc %h is not word aligned", pc);
    end

    // one reset edge is enough to clear the memory stage
    strobes_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |=> (!mem_re && !mem_we))
    else begin
        fail_count++;
        $error("memory strobe active while the core is held in reset");
    end

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (dbg_reg_addr == '0) |-> (dbg_reg_data == '0))
    else begin
        fail_count++;
        $error("x0 reads %h through the debug port", dbg_reg_data);
    end

endmodule

// File: rv5_core.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_core
    import rv5_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    output logic [`RV_XLEN-1:0]       pc,
    input  logic [`RV_XLEN-1:0]       instruction,
    output logic [`RV_XLEN-1:0]       mem_addr,
    output logic [`RV_XLEN-1:0]       mem_wdata,
    output logic                      mem_re,
    output logic                      mem_we,
    input  logic [`RV_XLEN-1:0]       mem_rdata,
    input  logic [`RV_REG_ADDR_W-1:0] dbg_reg_addr,
    output logic [`RV_XLEN-1:0]       dbg_reg_data
);
    logic [`RV_XLEN-1:0]       dec_pc;
    logic [`RV_XLEN-1:0]       dec_instr;
    ctrl_t                     dec_ctrl;
    logic [`RV_XLEN-1:0]       dec_imm;
    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       dec_op2_base;
    logic [1:0]                fwd_op1_sel;
    logic [1:0]                fwd_op2_sel;
    logic [1:0]                fwd_rs2_sel;
    logic                      stall;
    logic                      dec_kill;
    ctrl_t                     exe_ctrl;
    logic [`RV_XLEN-1:0]       exe_pc;
    logic [`RV_XLEN-1:0]       exe_op1;
    logic [`RV_XLEN-1:0]       exe_op2;
    logic [`RV_XLEN-1:0]       exe_rs2;
    logic [`RV_XLEN-1:0]       exe_imm;
    logic [`RV_XLEN-1:0]       exe_alu;
    logic                      branch_taken;
    logic [`RV_XLEN-1:0]       branch_target;
    ctrl_t                     mem_ctrl;
    logic [`RV_XLEN-1:0]       mem_alu;
    logic [`RV_XLEN-1:0]       mem_result;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic                      wb_we;
    logic [`RV_XLEN-1:0]       wb_data;

    rv5_fwd_if fwd ();

    rv5_fetch u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .instruction   (instruction),
        .pc            (pc),
        .dec_pc        (dec_pc),
        .dec_instr     (dec_instr)
    );

    rv5_decoder u_decoder (
        .instr (dec_instr),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm)
    );

    rv5_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (dec_instr[19:15]),
        .rs2_addr (dec_instr[24:20]),
        .rd_addr  (wb_rd),
        .rd_data  (wb_data),
        .we       (wb_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_reg_addr),
        .dbg_data (dbg_reg_data)
    );

    rv5_hazard_unit u_hazard (
        .dec_rs1      (dec_instr[19:15]),
        .dec_rs2      (dec_instr[24:20]),
        .fwd          (fwd),
        .dec_use_imm  (dec_ctrl.use_imm),
        .branch_taken (branch_taken),
        .fwd_op1_sel  (fwd_op1_sel),
        .fwd_op2_sel  (fwd_op2_sel),
        .fwd_rs2_sel  (fwd_rs2_sel),
        .stall        (stall),
        .dec_kill     (dec_kill)
    );

    // forwarding mux shared by op1, op2 and store data
    function automatic logic [`RV_XLEN-1:0] fwd_pick(input logic [1:0] sel,
                                                      input logic [`RV_XLEN-1:0] base);
        case (sel)
            `RV_FWD_EXE: return fwd.exe_result;
            `RV_FWD_MEM: return fwd.mem_result;
            `RV_FWD_WB:  return fwd.wb_data;
            default:     return base;
        endcase
    endfunction

    assign dec_op2_base = dec_ctrl.use_imm ? dec_imm : rs2_data;

    // DEC/EXE control, bubbled on stall or taken branch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_ctrl <= '0;
        end else if (dec_kill) begin
            exe_ctrl <= '0;
        end else begin
            exe_ctrl <= dec_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        exe_pc  <= dec_pc;
        exe_op1 <= fwd_pick(fwd_op1_sel, rs1_data);
        exe_op2 <= fwd_pick(fwd_op2_sel, dec_op2_base);
        exe_rs2 <= fwd_pick(fwd_rs2_sel, rs2_data);
        exe_imm <= dec_imm;
    end

    rv5_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl          (exe_ctrl),
        .pc            (exe_pc),
        .op1           (exe_op1),
        .op2           (exe_op2),
        .rs2           (exe_rs2),
        .imm           (exe_imm),
        .result        (exe_alu),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_ctrl      (mem_ctrl),
        .mem_alu       (mem_alu),
        .mem_wdata     (mem_wdata)
    );

    // memory stage
    assign mem_addr = mem_alu;
    assign mem_re   = mem_ctrl.mem_re;
    assign mem_we   = mem_ctrl.mem_we;

    always_comb begin
        case (mem_ctrl.wb_sel)
            WB_ALU:  mem_result = mem_alu;
            WB_MEM:  mem_result = mem_rdata;
            default: mem_result = '0;
        endcase
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= mem_ctrl.reg_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= mem_ctrl.rd;
        wb_data <= mem_result;
    end

    // feedback to decode
    assign fwd.exe_rd      = exe_ctrl.rd;
    assign fwd.exe_we      = exe_ctrl.reg_we;
    assign fwd.exe_is_load = exe_ctrl.mem_re;
    assign fwd.exe_result  = exe_alu;
    assign fwd.mem_rd      = mem_ctrl.rd;
    assign fwd.mem_we      = mem_ctrl.reg_we;
    assign fwd.mem_result  = mem_result;
    assign fwd.wb_rd       = wb_rd;
    assign fwd.wb_we       = wb_we;
    assign fwd.wb_data     = wb_data;

endmodule

// File: rv5_execute.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_execute
    import rv5_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_t               ctrl,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] op1,
    input  logic [`RV_XLEN-1:0] op2,
    input  logic [`RV_XLEN-1:0] rs2,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] result,
    output logic                branch_taken,
    output logic [`RV_XLEN-1:0] branch_target,
    output ctrl_t               mem_ctrl,
    output logic [`RV_XLEN-1:0] mem_alu,
    output logic [`RV_XLEN-1:0] mem_wdata
);
    logic is_eq;
    logic is_lt;

    assign is_lt = $signed(op1) < $signed(op2);

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = op1 + op2;
            ALU_SUB: result = op1 - op2;
            ALU_AND: result = op1 & op2;
            ALU_OR:  result = op1 | op2;
            ALU_XOR: result = op1 ^ op2;
            ALU_SLT: result = {{(`RV_XLEN-1){1'b0}}, is_lt};
            default: result = op1 + op2;
        endcase
    end

    // branches run ALU_SUB, so zero means equal
    assign is_eq         = (result == '0);
    assign branch_taken  = (ctrl.is_beq && is_eq) || (ctrl.is_bne && !is_eq);
    assign branch_target = pc + imm;

    // EXE/MEM control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ctrl <= '0;
        end else begin
            mem_ctrl <= ctrl;
            if (branch_taken) begin
                mem_ctrl.reg_we <= 1'b0;
            end
        end
    end

    // EXE/MEM payload
    always_ff @(posedge clk) begin
        mem_alu   <= result;
        mem_wdata <= rs2;
    end

endmodule

// File: rv5_regfile.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`RV_REG_ADDR_W-1:0] rs1_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rs2_addr,
    input  logic [`RV_REG_ADDR_W-1:0] rd_addr,
    input  logic [`RV_XLEN-1:0]       rd_data,
    input  logic                      we,
    output logic [`RV_XLEN-1:0]       rs1_data,
    output logic [`RV_XLEN-1:0]       rs2_data,
    input  logic [`RV_REG_ADDR_W-1:0] dbg_addr,
    output logic [`RV_XLEN-1:0]       dbg_data
);
    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign dbg_data = regs[dbg_addr];

endmodule

// File: rv5_hazard_unit.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_hazard_unit (
    input  logic [`RV_REG_ADDR_W-1:0] dec_rs1,
    input  logic [`RV_REG_ADDR_W-1:0] dec_rs2,
    rv5_fwd_if.hazard                 fwd,
    input  logic                      dec_use_imm,
    input  logic                      branch_taken,
    output logic [1:0]                fwd_op1_sel,
    output logic [1:0]                fwd_op2_sel,
    output logic [1:0]                fwd_rs2_sel,
    output logic                      stall,
    output logic                      dec_kill
);
    logic load_use;

    // youngest writer of rs wins, x0 never forwards
    function automatic logic [1:0] pick_src(input logic [`RV_REG_ADDR_W-1:0] rs);
        if (rs == '0) begin
            return `RV_FWD_REG;
        end
        if (fwd.exe_we && fwd.exe_rd == rs) begin
            return `RV_FWD_EXE;
        end
        if (fwd.mem_we && fwd.mem_rd == rs) begin
            return `RV_FWD_MEM;
        end
        if (fwd.wb_we && fwd.wb_rd == rs) begin
            return `RV_FWD_WB;
        end
        return `RV_FWD_REG;
    endfunction

    assign fwd_op1_sel = pick_src(dec_rs1);
    // immediate operand is never replaced
    assign fwd_op2_sel = dec_use_imm ? `RV_FWD_REG : pick_src(dec_rs2);
    // store data
    assign fwd_rs2_sel = pick_src(dec_rs2);

    // load data only exists from the memory stage on
    assign load_use = fwd.exe_is_load && fwd.exe_we && (fwd.exe_rd != '0) &&
                      ((fwd.exe_rd == dec_rs1) || (fwd.exe_rd == dec_rs2));

    assign stall    = load_use;
    assign dec_kill = load_use || branch_taken;

endmodule

// File: rv5_decoder.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_decoder
    import rv5_pkg::*;
(
    input  logic [`RV_XLEN-1:0] instr,
    output ctrl_t               ctrl,
    output logic [`RV_XLEN-1:0] imm
);
    opcode_e                   opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       imm_i;
    logic [`RV_XLEN-1:0]       imm_s;
    logic [`RV_XLEN-1:0]       imm_b;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    // sign extended immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            OP: begin
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default:              ctrl = '0;
                endcase
            end
            OP_IMM: begin
                // only addi
                if (funct3 == 3'b000) begin
                    ctrl.alu_op  = ALU_ADD;
                    ctrl.use_imm = 1'b1;
                    ctrl.wb_sel  = WB_ALU;
                    ctrl.reg_we  = 1'b1;
                end
            end
            LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.use_imm = 1'b1;
                    ctrl.wb_sel  = WB_MEM;
                    ctrl.reg_we  = 1'b1;
                    ctrl.mem_re  = 1'b1;
                end
            end
            STORE: begin
                imm = imm_s;
                if (funct3 == 3'b010) begin
                    ctrl.use_imm = 1'b1;
                    ctrl.mem_we  = 1'b1;
                end
            end
            BRANCH: begin
                // compare through the subtractor, imm is the target offset
                imm = imm_b;
                ctrl.alu_op = ALU_SUB;
                ctrl.is_beq = (funct3 == 3'b000);
                ctrl.is_bne = (funct3 == 3'b001);
                if (!ctrl.is_beq && !ctrl.is_bne) begin
                    ctrl = '0;
                end
            end
            default: ctrl = '0;
        endcase
        // results for x0 are dropped here so no stage forwards them
        ctrl.rd = ctrl.reg_we ? rd : '0;
        if (rd == '0) begin
            ctrl.reg_we = 1'b0;
        end
    end

endmodule

// File: rv5_fetch.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

module rv5_fetch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                branch_taken,
    input  logic [`RV_XLEN-1:0] branch_target,
    input  logic [`RV_XLEN-1:0] instruction,
    output logic [`RV_XLEN-1:0] pc,
    output logic [`RV_XLEN-1:0] dec_pc,
    output logic [`RV_XLEN-1:0] dec_instr
);
    logic [`RV_XLEN-1:0] pc_plus4;

    assign pc_plus4 = pc + `RV_XLEN'd4;

    // pc and IF/DEC instruction, a taken branch overrides a stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= `RV_RESET_PC;
            dec_instr <= `RV_NOP;
        end else if (branch_taken) begin
            pc        <= branch_target;
            // wrong-path fetch is killed
            dec_instr <= `RV_NOP;
        end else if (!stall) begin
            pc        <= pc_plus4;
            dec_instr <= instruction;
        end
    end

    // pc of the instruction in decode
    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_pc <= pc;
        end
    end

endmodule

// File: rv5_fwd_if.sv
`timescale 1ns/1ps
`include "rv5_defines.svh"

// results of the later stages, fed back to decode
interface rv5_fwd_if;
    logic [`RV_REG_ADDR_W-1:0] exe_rd;
    logic                      exe_we;
    logic                      exe_is_load;
    logic [`RV_XLEN-1:0]       exe_result;
    logic [`RV_REG_ADDR_W-1:0] mem_rd;
    logic                      mem_we;
    logic [`RV_XLEN-1:0]       mem_result;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic                      wb_we;
    logic [`RV_XLEN-1:0]       wb_data;

    modport src (output exe_rd, exe_we, exe_is_load, exe_result, mem_rd, mem_we,
                 mem_result, wb_rd, wb_we, wb_data);
    // hazard detection only needs the destinations
    modport hazard (input exe_rd, exe_we, exe_is_load, mem_rd, mem_we, wb_rd, wb_we);
endinterface

// File: rv5_pkg.sv
`include "rv5_defines.svh"

package rv5_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // source of the result leaving the memory stage
    typedef enum logic [1:0] {
        WB_NONE = 2'd0,
        WB_ALU  = 2'd1,
        WB_MEM  = 2'd2
    } wb_sel_e;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e                   alu_op;
        logic                      use_imm;
        wb_sel_e                   wb_sel;
        logic                      reg_we;
        logic                      mem_re;
        logic                      mem_we;
        logic                      is_beq;
        logic                      is_bne;
        logic [`RV_REG_ADDR_W-1:0] rd;
    } ctrl_t;

endpackage

// File: rv5_defines.svh
`ifndef RV5_DEFINES_SVH
`define RV5_DEFINES_SVH

// datapath and register file sizes
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// addi x0, x0, 0
`define RV_NOP         32'h0000_0013
`define RV_RESET_PC    32'h0000_0000

// operand forwarding sources, youngest stage wins
`define RV_FWD_REG     2'd0
`define RV_FWD_EXE     2'd1
`define RV_FWD_MEM     2'd2
`define RV_FWD_WB      2'd3

`endif
